// File: rtl/chitchat_macros.svh
// ChitChat receive constants
// Frame layout, comma byte, protocol id and link qualification limits
`ifndef CHITCHAT_MACROS_SVH
`define CHITCHAT_MACROS_SVH

// Words per frame, comma word through CRC word
`define CC_FRAME_WORDS 11

// Comma byte in the low byte of word 0
`define CC_COMMA 8'hBC

// Expected protocol category in word 0
`define CC_PROTOCOL_CAT 4'hA

// Clean frames in a row before valid is passed on
`define CC_LINK_UP_CNT 3

// Idle cycles after the last word index that mean loss of sync
`define CC_SYNC_TIMEOUT 15

`endif

// File: rtl/chitchat_pkg.sv
// ChitChat receive types
// Link word, frame index, field and fault types shared by the receive blocks
package chitchat_pkg;

   // ----------------------------------------------------------------------
   // Link words
   // ----------------------------------------------------------------------

   // One transceiver word
   typedef logic [15:0] cc_word_t;

   // Word position in a frame
   // Saturates at 15 between frames
   typedef logic [3:0] cc_widx_t;

   // Rev id and data fields, two link words, high word first
   typedef logic [31:0] cc_word32_t;

   // ----------------------------------------------------------------------
   // Status
   // ----------------------------------------------------------------------

   // Fault vector
   // [0] wrong protocol category
   // [1] CRC fail
   // [2] wrong frame number
   typedef logic [2:0] cc_fault_t;

   // Running count of faulty frames, wraps
   typedef logic [15:0] cc_fault_cnt_t;

   // Aligner FSM
   // HUNT waits for a comma, IN_FRAME walks indices 0 to 10
   typedef enum logic {
      HUNT,
      IN_FRAME
   } cc_align_state_t;

endpackage

// File: rtl/chitchat_word_if.sv
// ChitChat aligned word channel
// Carries framed words from the aligner to the CRC and field checkers
`timescale 1ns/1ps

interface chitchat_word_if;
   import chitchat_pkg::*;

   // Registered link word
   cc_word_t word;
   // Index of the word in its frame
   cc_widx_t widx;
   // Word belongs to a frame, indices 0 to 10
   logic     word_valid;
   // CRC word on the channel, last of the frame
   logic     frame_end;
   // Loss of sync level
   logic     los;

   // Aligner side
   modport src (
      output word,
      output widx,
      output word_valid,
      output frame_end,
      output los
   );

   // Checker side
   modport snk (
      input word,
      input widx,
      input word_valid,
      input frame_end,
      input los
   );

endinterface

// File: rtl/cc_rx_aligner.sv
// ChitChat frame aligner
// Locks the word index to the comma word, flags frame end and loss of sync
`timescale 1ns/1ps
`include "chitchat_macros.svh"

module cc_rx_aligner (
   input  logic                   clk,
   input  logic                   arst_n,
   input  chitchat_pkg::cc_word_t gtx_d,
   input  logic                   gtx_k,
   chitchat_word_if.src           wif
);
   import chitchat_pkg::*;

   localparam cc_widx_t   LAST_IDX  = cc_widx_t'(`CC_FRAME_WORDS - 1);
   localparam cc_widx_t   IDX_SAT   = '1;
   localparam logic [4:0] TMO_LIMIT = 5'(`CC_SYNC_TIMEOUT);

   cc_align_state_t state;
   cc_align_state_t state_nxt;
   cc_widx_t        idx_nxt;
   logic            comma;
   logic            last_nxt;
   logic [4:0]      tmo_cnt;

   // Comma word is K with the comma byte low
   assign comma = gtx_k && (gtx_d[7:0] == `CC_COMMA);

   // ----------------------------------------------------------------------
   // Word counter and FSM
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      idx_nxt   = wif.widx;
      if (comma) begin
         // Every comma restarts the frame
         state_nxt = IN_FRAME;
         idx_nxt   = '0;
      end else begin
         // Count on, hold at saturation between frames
         if (wif.widx != IDX_SAT)
            idx_nxt = wif.widx + 1'b1;
         // Frame over once the CRC word has gone by
         if ((state == IN_FRAME) && (wif.widx == LAST_IDX))
            state_nxt = HUNT;
      end
   end

   // Next word is the CRC word of a frame
   assign last_nxt = (state_nxt == IN_FRAME) && (idx_nxt == LAST_IDX);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state         <= HUNT;
         wif.widx      <= IDX_SAT;
         wif.frame_end <= 1'b0;
         wif.los       <= 1'b0;
         tmo_cnt       <= '0;
      end else begin
         state         <= state_nxt;
         wif.widx      <= idx_nxt;
         wif.frame_end <= last_nxt;
         // Idle cycles since the last in-frame word
         if (state_nxt == IN_FRAME)
            tmo_cnt <= '0;
         else if (tmo_cnt != TMO_LIMIT)
            tmo_cnt <= tmo_cnt + 1'b1;
         // Sync comes back only with a whole frame
         if (last_nxt)
            wif.los <= 1'b0;
         else if ((state_nxt == HUNT) && (tmo_cnt == TMO_LIMIT - 1'b1))
            wif.los <= 1'b1;
      end
   end

   assign wif.word_valid = (state == IN_FRAME);

   // Data path register
   always_ff @(posedge clk) begin
      wif.word <= gtx_d;
   end

   // Transmitter never cuts a frame short with a new comma
   a_no_comma_mid_frame : assert property (
      @(posedge clk) disable iff (!arst_n)
      comma |-> !((state == IN_FRAME) && (wif.widx != LAST_IDX))
   );

endmodule

// File: rtl/cc_crc16.sv
// CRC-16 engine, polynomial x^16+x^12+x^5+1
// Folds one word per enabled clock, MSB first, zero seed, no final XOR
`timescale 1ns/1ps

module cc_crc16 (
   input  logic                   clk,
   input  logic                   arst_n,
   input  chitchat_pkg::cc_word_t din,
   input  logic                   en,
   input  logic                   restart,
   output chitchat_pkg::cc_word_t crc
);
   import chitchat_pkg::*;

   localparam cc_word_t POLY = 16'h1021;

   cc_word_t seed;
   cc_word_t crc_nxt;

   // Shift one word through the LFSR, MSB first
   function automatic cc_word_t crc_word(input cc_word_t c_in, input cc_word_t d);
      cc_word_t c;
      logic     fb;
      c = c_in;
      for (int i = 15; i >= 0; i--) begin
         fb = c[15] ^ d[i];
         c  = {c[14:0], 1'b0};
         if (fb)
            c = c ^ POLY;
      end
      return c;
   endfunction

   // Restart seeds zero under the incoming word
   assign seed    = restart ? '0 : crc;
   assign crc_nxt = crc_word(seed, din);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         crc <= '0;
      else if (en)
         crc <= crc_nxt;
   end

endmodule

// File: rtl/cc_rx_crc_check.sv
// ChitChat CRC checker
// Runs the CRC over every frame and reports a zero residual after the CRC word
`timescale 1ns/1ps

module cc_rx_crc_check (
   input  logic         clk,
   input  logic         arst_n,
   chitchat_word_if.snk wif,
   output logic         crc_ok,
   output logic         crc_done
);
   import chitchat_pkg::*;

   cc_word_t residual;
   logic     first_word;

   // Word 0 restarts the engine
   assign first_word = wif.word_valid && (wif.widx == '0);

   // Words 0 to 10, CRC word included
   cc_crc16 i_crc16 (
      .clk     (clk),
      .arst_n  (arst_n),
      .din     (wif.word),
      .en      (wif.word_valid),
      .restart (first_word),
      .crc     (residual)
   );

   // CRC word folds in on the frame end cycle
   // Result is ready one clock later
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         crc_done <= 1'b0;
      else
         crc_done <= wif.frame_end;
   end

   // Good frame leaves a zero residual
   // Held until word 0 of the next frame
   assign crc_ok = (residual == '0);

endmodule

// File: rtl/cc_rx_field_decoder.sv
// ChitChat field decoder
// Unpacks the frame fields, checks protocol category and frame sequence
`timescale 1ns/1ps
`include "chitchat_macros.svh"

module cc_rx_field_decoder (
   input  logic                     clk,
   input  logic                     arst_n,
   chitchat_word_if.snk             wif,
   input  chitchat_pkg::cc_fault_t  prev_fault,
   output logic [3:0]               protocol_ver,
   output logic [2:0]               gateware_type,
   output logic [2:0]               location,
   output chitchat_pkg::cc_word32_t rev_id,
   output chitchat_pkg::cc_word32_t data0,
   output chitchat_pkg::cc_word32_t data1,
   output chitchat_pkg::cc_word_t   frame_counter,
   output chitchat_pkg::cc_word_t   loopback_frame_counter,
   output logic                     prot_bad,
   output logic                     seq_bad,
   output logic                     fields_done
);
   import chitchat_pkg::*;

   localparam cc_widx_t LAST_IDX = cc_widx_t'(`CC_FRAME_WORDS - 1);

   // Staging copies filled by index and published at frame end
   logic [3:0] cat_s;
   logic [3:0] ver_s;
   logic [2:0] gw_s;
   logic [2:0] loc_s;
   cc_word32_t rev_s;
   cc_word32_t d0_s;
   cc_word32_t d1_s;
   cc_word_t   fc_s;
   cc_word_t   lfc_s;

   logic       have_prev;
   logic       seq_skip;
   cc_word_t   fc_expect;

   // ----------------------------------------------------------------------
   // Capture by word index
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (wif.word_valid) begin
         case (wif.widx)
            // Category, version, comma byte
            4'd0: begin
               cat_s <= wif.word[15:12];
               ver_s <= wif.word[11:8];
            end
            // Gateware type and location with the reserved bits ignored
            4'd1: begin
               gw_s  <= wif.word[15:13];
               loc_s <= wif.word[12:10];
            end
            // 32-bit fields with the high word first
            4'd2: rev_s[31:16] <= wif.word;
            4'd3: rev_s[15:0]  <= wif.word;
            4'd4: d0_s[31:16]  <= wif.word;
            4'd5: d0_s[15:0]   <= wif.word;
            4'd6: d1_s[31:16]  <= wif.word;
            4'd7: d1_s[15:0]   <= wif.word;
            4'd8: fc_s         <= wif.word;
            4'd9: lfc_s        <= wif.word;
            // CRC word stays with the CRC checker
            default: ;
         endcase
      end
   end

   // Published set stays stable across the next frame's first words
   always_ff @(posedge clk) begin
      if (wif.frame_end) begin
         protocol_ver           <= ver_s;
         gateware_type          <= gw_s;
         location               <= loc_s;
         rev_id                 <= rev_s;
         data0                  <= d0_s;
         data1                  <= d1_s;
         frame_counter          <= fc_s;
         loopback_frame_counter <= lfc_s;
      end
   end

   // ----------------------------------------------------------------------
   // Protocol and sequence checks
   // ----------------------------------------------------------------------
   // Previous published counter plus one
   assign fc_expect = frame_counter + 1'b1;
   // No reference after reset, loss of sync or a faulty frame
   assign seq_skip  = !have_prev || (prev_fault != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fields_done <= 1'b0;
         prot_bad    <= 1'b0;
         seq_bad     <= 1'b0;
         have_prev   <= 1'b0;
      end else begin
         fields_done <= wif.frame_end;
         if (wif.frame_end) begin
            prot_bad  <= (cat_s != `CC_PROTOCOL_CAT);
            seq_bad   <= !seq_skip && (fc_s != fc_expect);
            have_prev <= 1'b1;
         end else if (wif.los) begin
            have_prev <= 1'b0;
         end
      end
   end

   // Results come one clock after the in-frame CRC word at the last index
   a_fields_after_end : assert property (
      @(posedge clk) disable iff (!arst_n)
      fields_done |-> $past(wif.frame_end && wif.word_valid && (wif.widx == LAST_IDX))
   );

endmodule

// File: rtl/cc_rx_link_monitor.sv
// ChitChat link monitor
// Merges checker results into fault status, fault count, drop and qualified valid
`timescale 1ns/1ps
`include "chitchat_macros.svh"

module cc_rx_link_monitor (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        crc_ok,
   input  logic                        crc_done,
   input  logic                        prot_bad,
   input  logic                        seq_bad,
   input  logic                        fields_done,
   input  logic                        los,
   output chitchat_pkg::cc_fault_t     fault,
   output chitchat_pkg::cc_fault_cnt_t fault_cnt,
   output logic                        frame_drop,
   output logic                        valid
);
   import chitchat_pkg::*;

   localparam logic [3:0] LINK_UP = 4'(`CC_LINK_UP_CNT);

   cc_fault_t  faults;
   logic       result;
   logic       link_up;
   logic [3:0] link_cnt;

   // Bit order: sequence, CRC, protocol
   assign faults  = {seq_bad, ~crc_ok, prot_bad};
   // Both checkers report together
   assign result  = crc_done && fields_done;
   // Enough clean frames seen in a row
   assign link_up = (link_cnt == LINK_UP);

   // ----------------------------------------------------------------------
   // Frame result handling
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fault      <= '0;
         fault_cnt  <= '0;
         frame_drop <= 1'b0;
         valid      <= 1'b0;
         link_cnt   <= '0;
      end else begin
         // Single cycle strobes
         frame_drop <= 1'b0;
         valid      <= 1'b0;
         if (result) begin
            if (faults != '0) begin
               // Latch the fault and requalify from scratch
               fault      <= faults;
               fault_cnt  <= fault_cnt + 1'b1;
               link_cnt   <= '0;
               frame_drop <= 1'b1;
            end else begin
               fault      <= '0;
               valid      <= link_up;
               // Clean but still qualifying, dropped
               frame_drop <= !link_up;
               if (!link_up)
                  link_cnt <= link_cnt + 1'b1;
            end
         end
         // Loss of sync restarts qualification
         if (los)
            link_cnt <= '0;
      end
   end

   // CRC and field checkers stay in lock step
   a_results_aligned : assert property (
      @(posedge clk) disable iff (!arst_n)
      (crc_done || fields_done) |-> (crc_done && fields_done)
   );

endmodule

// File: rtl/chitchat_rx.sv
// ChitChat receive top level
// Aligns the transceiver stream, checks CRC and fields, reports link status
`timescale 1ns/1ps

module chitchat_rx (
   input  logic                        clk,
   input  logic                        arst_n,
   input  chitchat_pkg::cc_word_t      gtx_d,
   input  logic                        gtx_k,
   output chitchat_pkg::cc_fault_t     ccrx_fault,
   output chitchat_pkg::cc_fault_cnt_t ccrx_fault_cnt,
   output logic                        ccrx_los,
   output logic                        ccrx_frame_drop,
   output logic                        rx_valid,
   output logic [3:0]                  rx_protocol_ver,
   output logic [2:0]                  rx_gateware_type,
   output logic [2:0]                  rx_location,
   output chitchat_pkg::cc_word32_t    rx_rev_id,
   output chitchat_pkg::cc_word32_t    rx_data0,
   output chitchat_pkg::cc_word32_t    rx_data1,
   output chitchat_pkg::cc_word_t      rx_frame_counter,
   output chitchat_pkg::cc_word_t      rx_loopback_frame_counter
);

   // Checker results into the monitor
   logic crc_ok;
   logic crc_done;
   logic prot_bad;
   logic seq_bad;
   logic fields_done;

   // Aligned word channel
   chitchat_word_if wif ();

   cc_rx_aligner i_aligner (
      .clk    (clk),
      .arst_n (arst_n),
      .gtx_d  (gtx_d),
      .gtx_k  (gtx_k),
      .wif    (wif.src)
   );

   cc_rx_crc_check i_crc_check (
      .clk      (clk),
      .arst_n   (arst_n),
      .wif      (wif.snk),
      .crc_ok   (crc_ok),
      .crc_done (crc_done)
   );

   // Fault status feeds back to gate the sequence check
   cc_rx_field_decoder i_field_decoder (
      .clk                    (clk),
      .arst_n                 (arst_n),
      .wif                    (wif.snk),
      .prev_fault             (ccrx_fault),
      .protocol_ver           (rx_protocol_ver),
      .gateware_type          (rx_gateware_type),
      .location               (rx_location),
      .rev_id                 (rx_rev_id),
      .data0                  (rx_data0),
      .data1                  (rx_data1),
      .frame_counter          (rx_frame_counter),
      .loopback_frame_counter (rx_loopback_frame_counter),
      .prot_bad               (prot_bad),
      .seq_bad                (seq_bad),
      .fields_done            (fields_done)
   );

   cc_rx_link_monitor i_link_monitor (
      .clk         (clk),
      .arst_n      (arst_n),
      .crc_ok      (crc_ok),
      .crc_done    (crc_done),
      .prot_bad    (prot_bad),
      .seq_bad     (seq_bad),
      .fields_done (fields_done),
      .los         (wif.los),
      .fault       (ccrx_fault),
      .fault_cnt   (ccrx_fault_cnt),
      .frame_drop  (ccrx_frame_drop),
      .valid       (rx_valid)
   );

   // Loss of sync straight from the aligner
   assign ccrx_los = wif.los;

endmodule

// File: dv/chitchat_frame_model.svh
// ChitChat testbench frame model
// Builds frames with their CRC, drives them and compares DUT outputs
`ifndef CHITCHAT_FRAME_MODEL_SVH
`define CHITCHAT_FRAME_MODEL_SVH

// Frame content as sent, CRC word added on the way out
typedef struct packed {
   logic [3:0] cat;
   logic [3:0] ver;
   logic [2:0] gw;
   logic [2:0] loc;
   cc_word32_t rev;
   cc_word32_t d0;
   cc_word32_t d1;
   cc_word_t   fc;
   cc_word_t   lfc;
} frame_t;

// ----------------------------------------------------------------------
// Frame builder
// ----------------------------------------------------------------------

// x^16+x^12+x^5+1, one word MSB first
function automatic cc_word_t crc_step(input cc_word_t c, input cc_word_t d);
   cc_word_t r;
   r = c;
   for (int b = 15; b >= 0; b--)
      r = (r[15] ^ d[b]) ? ((r << 1) ^ 16'h1021) : (r << 1);
   return r;
endfunction

// Word at a frame index, CRC word excluded
function automatic cc_word_t frame_word(input frame_t f, input int idx);
   case (idx)
      0: return {f.cat, f.ver, `CC_COMMA};
      // Reserved bits sent as zero
      1: return {f.gw, f.loc, 10'h000};
      2: return f.rev[31:16];
      3: return f.rev[15:0];
      4: return f.d0[31:16];
      5: return f.d0[15:0];
      6: return f.d1[31:16];
      7: return f.d1[15:0];
      8: return f.fc;
      9: return f.lfc;
      default: return '0;
   endcase
endfunction

// Random payload, next frame number in sequence
task automatic next_frame(output frame_t f);
   f.cat = `CC_PROTOCOL_CAT;
   f.ver = 4'($urandom);
   f.gw  = 3'($urandom);
   f.loc = 3'($urandom);
   f.rev = $urandom;
   f.d0  = $urandom;
   f.d1  = $urandom;
   f.fc  = tx_fc;
   f.lfc = 16'($urandom);
   tx_fc = tx_fc + 1'b1;
endtask

// Eleven words on falling edges, comma first
// flip corrupts word 4 after the CRC is formed
task automatic send_frame(input frame_t f, input cc_word_t flip);
   cc_word_t crc;
   cc_word_t w;
   crc = '0;
   for (int i = 0; i < `CC_FRAME_WORDS - 1; i++)
      crc = crc_step(crc, frame_word(f, i));
   for (int i = 0; i < `CC_FRAME_WORDS; i++) begin
      w = (i == `CC_FRAME_WORDS - 1) ? crc : frame_word(f, i);
      if (i == 4)
         w = w ^ flip;
      @(negedge clk);
      gtx_k = (i == 0);
      gtx_d = w;
   end
   idle_cnt = 0;
endtask

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic fail_run(input string why);
   $display("%s", why);
   $display("*** TEST FAILED ***");
   $fatal(1);
endtask

task automatic compare_word32(input string name, input cc_word32_t exp, input cc_word32_t act);
   if (act !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act));
endtask

task automatic compare_word(input string name, input cc_word_t exp, input cc_word_t act);
   if (act !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act));
endtask

task automatic compare_fault(input string name, input cc_fault_t exp, input cc_fault_t act);
   if (act !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act));
endtask

task automatic compare_cnt(input string name, input cc_fault_cnt_t exp,
                           input cc_fault_cnt_t act);
   if (act !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act));
endtask

// Every published field against what was sent
task automatic compare_fields(input frame_t f);
   compare_word("rx_protocol_ver", cc_word_t'(f.ver), cc_word_t'(rx_protocol_ver));
   compare_word("rx_gateware_type", cc_word_t'(f.gw), cc_word_t'(rx_gateware_type));
   compare_word("rx_location", cc_word_t'(f.loc), cc_word_t'(rx_location));
   compare_word32("rx_rev_id", f.rev, rx_rev_id);
   compare_word32("rx_data0", f.d0, rx_data0);
   compare_word32("rx_data1", f.d1, rx_data1);
   compare_word("rx_frame_counter", f.fc, rx_frame_counter);
   compare_word("rx_loopback_frame_counter", f.lfc, rx_loopback_frame_counter);
endtask

`endif

// File: dv/tb_chitchat_rx.sv
// ChitChat receive testbench
// Acts as the transmitter, checks link qualification, faults, sync and fields
`timescale 1ns/1ps
`include "chitchat_macros.svh"

module tb_chitchat_rx;
   import chitchat_pkg::*;

   localparam int WAIT_LIMIT = 40;
   localparam int N_STREAM   = 20;

   logic          clk;
   logic          arst_n;
   cc_word_t      gtx_d;
   logic          gtx_k;
   cc_fault_t     ccrx_fault;
   cc_fault_cnt_t ccrx_fault_cnt;
   logic          ccrx_los;
   logic          ccrx_frame_drop;
   logic          rx_valid;
   logic [3:0]    rx_protocol_ver;
   logic [2:0]    rx_gateware_type;
   logic [2:0]    rx_location;
   cc_word32_t    rx_rev_id;
   cc_word32_t    rx_data0;
   cc_word32_t    rx_data1;
   cc_word_t      rx_frame_counter;
   cc_word_t      rx_loopback_frame_counter;

   // Expected fault count, next frame number, idle words since the last frame
   cc_fault_cnt_t exp_cnt;
   cc_word_t      tx_fc;
   int            idle_cnt;

   `include "chitchat_frame_model.svh"

   frame_t stream_f [N_STREAM];

   chitchat_rx i_dut (
      .clk                       (clk),
      .arst_n                    (arst_n),
      .gtx_d                     (gtx_d),
      .gtx_k                     (gtx_k),
      .ccrx_fault                (ccrx_fault),
      .ccrx_fault_cnt            (ccrx_fault_cnt),
      .ccrx_los                  (ccrx_los),
      .ccrx_frame_drop           (ccrx_frame_drop),
      .rx_valid                  (rx_valid),
      .rx_protocol_ver           (rx_protocol_ver),
      .rx_gateware_type          (rx_gateware_type),
      .rx_location               (rx_location),
      .rx_rev_id                 (rx_rev_id),
      .rx_data0                  (rx_data0),
      .rx_data1                  (rx_data1),
      .rx_frame_counter          (rx_frame_counter),
      .rx_loopback_frame_counter (rx_loopback_frame_counter)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Frame result handling
   // ----------------------------------------------------------------------
   task automatic drive_idle();
      gtx_k    = 1'b0;
      gtx_d    = '0;
      idle_cnt = idle_cnt + 1;
   endtask

   // Outputs sampled on falling edges with idle words sent meanwhile if asked
   task automatic wait_result(input bit drive);
      bit seen;
      seen = 1'b0;
      for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
         @(negedge clk);
         if (drive)
            drive_idle();
         seen = rx_valid || ccrx_frame_drop;
      end
      if (!seen)
         fail_run("no rx_valid or frame drop after the CRC word");
   endtask

   // A frame is either passed on or dropped and never both
   task automatic check_result(input frame_t f, input logic exp_valid,
                               input cc_fault_t exp_fault, input bit drive);
      wait_result(drive);
      compare_bit("rx_valid", exp_valid, rx_valid);
      compare_bit("ccrx_frame_drop", !exp_valid, ccrx_frame_drop);
      compare_fault("ccrx_fault", exp_fault, ccrx_fault);
      if (exp_fault != '0)
         exp_cnt = exp_cnt + 1'b1;
      compare_cnt("ccrx_fault_cnt", exp_cnt, ccrx_fault_cnt);
      if (exp_valid)
         compare_fields(f);
   endtask

   task automatic send_and_check(input frame_t f, input cc_word_t flip,
                                 input logic exp_valid, input cc_fault_t exp_fault);
      send_frame(f, flip);
      check_result(f, exp_valid, exp_fault, 1'b1);
   endtask

   // Clean frames dropped while qualifying and then the first valid one
   task automatic requalify(input int drops);
      frame_t f;
      for (int k = 0; k < drops; k++) begin
         next_frame(f);
         send_and_check(f, '0, 1'b0, '0);
      end
      next_frame(f);
      send_and_check(f, '0, 1'b1, '0);
   endtask

   // ----------------------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------------------
   task automatic test_link_up();
      compare_bit("rx_valid", 1'b0, rx_valid);
      compare_bit("ccrx_frame_drop", 1'b0, ccrx_frame_drop);
      compare_bit("ccrx_los", 1'b0, ccrx_los);
      compare_fault("ccrx_fault", '0, ccrx_fault);
      compare_cnt("ccrx_fault_cnt", '0, ccrx_fault_cnt);
      requalify(`CC_LINK_UP_CNT);
   endtask

   task automatic test_crc_fault();
      frame_t f;
      next_frame(f);
      send_and_check(f, 16'h0100, 1'b0, 3'b010);
      requalify(`CC_LINK_UP_CNT);
   endtask

   task automatic test_proto_seq();
      frame_t f;
      next_frame(f);
      f.cat = ~(`CC_PROTOCOL_CAT);
      send_and_check(f, '0, 1'b0, 3'b001);
      next_frame(f);
      send_and_check(f, '0, 1'b0, '0);
      // Counter skips after a clean frame
      tx_fc = tx_fc + 16'd3;
      next_frame(f);
      send_and_check(f, '0, 1'b0, 3'b100);
      // A second skip right after the fault goes unchecked
      tx_fc = tx_fc + 16'd7;
      requalify(`CC_LINK_UP_CNT);
   endtask

   task automatic test_los();
      frame_t f;
      bit     seen;
      seen = 1'b0;
      for (int i = 0; i < `CC_SYNC_TIMEOUT + 10 && !seen; i++) begin
         @(negedge clk);
         drive_idle();
         seen = ccrx_los;
      end
      if (!seen)
         fail_run("ccrx_los did not rise after the commas stopped");
      // Idle words counted include the one driven as the rise is seen
      if (idle_cnt != `CC_SYNC_TIMEOUT + 1)
         fail_run("ccrx_los rose at the wrong cycle after the commas stopped");
      // No sequence reference after loss of sync
      tx_fc = tx_fc + 16'd100;
      next_frame(f);
      send_and_check(f, '0, 1'b0, '0);
      compare_bit("ccrx_los", 1'b0, ccrx_los);
      requalify(`CC_LINK_UP_CNT - 1);
   endtask

   // Back to back frames with results checked while the next frame goes out
   task automatic test_streaming();
      for (int k = 0; k < N_STREAM; k++)
         next_frame(stream_f[k]);
      fork
         begin
            for (int k = 0; k < N_STREAM; k++)
               send_frame(stream_f[k], '0);
            @(negedge clk);
            drive_idle();
         end
         begin
            for (int k = 0; k < N_STREAM; k++)
               check_result(stream_f[k], 1'b1, '0, 1'b0);
         end
      join
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      void'($urandom(22587));
      arst_n   = 1'b0;
      gtx_d    = '0;
      gtx_k    = 1'b0;
      exp_cnt  = '0;
      idle_cnt = 0;
      tx_fc    = 16'($urandom);
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      test_link_up();
      test_crc_fault();
      test_proto_seq();
      test_los();
      test_streaming();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: flist.f
+incdir+rtl
+incdir+dv
rtl/chitchat_pkg.sv
rtl/chitchat_word_if.sv
rtl/cc_rx_aligner.sv
rtl/cc_crc16.sv
rtl/cc_rx_crc_check.sv
rtl/cc_rx_field_decoder.sv
rtl/cc_rx_link_monitor.sv
rtl/chitchat_rx.sv
dv/tb_chitchat_rx.sv
